/* all.f */
sps_pkg.sv
bit_window.sv
exp_golomb_decoder.sv
sps_field_sequencer.sv
sps_param_regs.sv
sps_parser_top.sv
sps_parser_checker.sv
tb_sps_parser.sv

/* tb_sps_parser.sv */
`timescale 1ns/1ns

module tb_sps_parser import sps_pkg::*;
();

    localparam int NUM_RUNS    = 4;
    localparam int RUN_LIMIT   = 2000;               // cycles per stream
    localparam int TOTAL_LIMIT = NUM_RUNS * RUN_LIMIT;

    logic        clk;
    logic        rst;
    logic        i_en;
    logic [7:0]  i_byte;
    logic        i_byte_valid;
    logic        o_need_byte;
    logic        o_done;
    sps_params_t o_params;

    sps_params_t exp_params;
    logic        bits_q[$];                          // encoded stream, msb first
    logic        slow;
    int          errors;
    int          run_cycles;
    int          total_cycles;

    sps_parser_top uut
    (
        .clk          (clk),
        .rst          (rst),
        .i_en         (i_en),
        .i_byte       (i_byte),
        .i_byte_valid (i_byte_valid),
        .o_need_byte  (o_need_byte),
        .o_params     (o_params),
        .o_done       (o_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // stream encoding
    // --------------------------------------------------
    task automatic put_bits(input int value, input int width);
        for (int i = width - 1; i >= 0; i--)
            bits_q.push_back(value[i]);
    endtask

    task automatic put_ue(input int value);
        int code;
        int len;
        code = value + 1;
        len  = 0;
        while ((code >> len) != 0)
            len++;
        put_bits(0, len - 1);                        // zero prefix
        put_bits(code, len);
    endtask

    task automatic build_stream(input int run);
        logic       conf;
        logic [3:0] grp;
        bits_q.delete();
        exp_params = '0;
        for (int i = 0; i < HEADER_SKIP_BITS; i++)
            bits_q.push_back(1'($urandom));
        put_ue($urandom_range(15));                  // sps id
        exp_params.chroma_format_idc = 2'($urandom_range(3));
        put_ue(exp_params.chroma_format_idc);
        if (run == 2)
            exp_params.pic_width = 13'(8191 - $urandom_range(3));
        else
            exp_params.pic_width = 13'($urandom);
        put_ue(exp_params.pic_width);
        exp_params.pic_height = 12'($urandom);
        put_ue(exp_params.pic_height);
        conf = (run == 0) ? 1'b1 : (run == 1) ? 1'b0 : 1'($urandom);
        put_bits(conf, 1);
        if (conf)
        begin
            for (int i = 0; i < 4; i++)
                put_ue(1 + $urandom_range(40));      // offsets, discarded
        end
        put_ue($urandom_range(4));
        put_ue($urandom_range(4));
        exp_params.log2_max_poc_lsb_minus4 = 4'($urandom);
        put_ue(exp_params.log2_max_poc_lsb_minus4);
        put_bits(1, 1);                              // sub-layer ordering flag
        exp_params.max_dec_pic_buffering_minus1 = (run == 2) ? 5'd31 : 5'($urandom);
        put_ue(exp_params.max_dec_pic_buffering_minus1);
        put_ue($urandom_range(6));
        put_ue($urandom_range(6));
        exp_params.log2_min_cb_minus3 = 2'($urandom);
        exp_params.log2_diff_cb       = 2'($urandom);
        exp_params.log2_min_tb_minus2 = 2'($urandom);
        exp_params.log2_diff_tb       = 2'($urandom);
        exp_params.depth_inter        = 3'($urandom);
        exp_params.depth_intra        = 3'($urandom);
        put_ue(exp_params.log2_min_cb_minus3);
        put_ue(exp_params.log2_diff_cb);
        put_ue(exp_params.log2_min_tb_minus2);
        put_ue(exp_params.log2_diff_tb);
        put_ue(exp_params.depth_inter);
        put_ue(exp_params.depth_intra);
        grp = 4'($urandom);
        put_bits(grp, 4);
        exp_params.amp_flag = grp[2];                // second bit sent
        exp_params.sao_flag = grp[1];
        exp_params.num_st_rps = 4'($urandom);
        put_ue(exp_params.num_st_rps);
        while (bits_q.size() % 8 != 0)
            bits_q.push_back(1'b0);
        put_bits(0, 24);                             // zero pad bytes
    endtask

    task automatic check_field(input string name, input int got, input int want);
        assert (got == want)
        else
        begin
            errors++;
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, name, got, want);
        end
    endtask

    task automatic run_stream(input int run);
        logic [7:0] b;
        build_stream(run);
        slow = run[0];
        @(posedge clk);
        #2;
        rst          = 1'b1;
        i_en         = 1'b0;
        i_byte_valid = 1'b0;
        repeat (2)
        begin
            @(posedge clk);
            #2;
        end
        rst        = 1'b0;
        run_cycles = 0;
        check_field("o_need_byte", o_need_byte, 1);  // empty window asks for data
        while (!o_done)
        begin
            i_en         = slow ? ($urandom_range(3) != 0) : 1'b1;
            i_byte_valid = 1'b0;
            if (o_need_byte && bits_q.size() >= 8 && (!slow || $urandom_range(2) == 0))
            begin
                for (int i = 0; i < 8; i++)
                    b = {b[6:0], bits_q.pop_front()};
                i_byte       = b;
                i_byte_valid = 1'b1;
            end
            @(posedge clk);
            #2;
        end
        i_en         = 1'b0;
        i_byte_valid = 1'b0;
        check_field("chroma_format_idc", o_params.chroma_format_idc,
                    exp_params.chroma_format_idc);
        check_field("pic_width", o_params.pic_width, exp_params.pic_width);
        check_field("pic_height", o_params.pic_height, exp_params.pic_height);
        check_field("log2_max_poc_lsb_minus4", o_params.log2_max_poc_lsb_minus4,
                    exp_params.log2_max_poc_lsb_minus4);
        check_field("max_dec_pic_buffering_minus1", o_params.max_dec_pic_buffering_minus1,
                    exp_params.max_dec_pic_buffering_minus1);
        check_field("log2_min_cb_minus3", o_params.log2_min_cb_minus3,
                    exp_params.log2_min_cb_minus3);
        check_field("log2_diff_cb", o_params.log2_diff_cb, exp_params.log2_diff_cb);
        check_field("log2_min_tb_minus2", o_params.log2_min_tb_minus2,
                    exp_params.log2_min_tb_minus2);
        check_field("log2_diff_tb", o_params.log2_diff_tb, exp_params.log2_diff_tb);
        check_field("depth_inter", o_params.depth_inter, exp_params.depth_inter);
        check_field("depth_intra", o_params.depth_intra, exp_params.depth_intra);
        check_field("amp_flag", o_params.amp_flag, exp_params.amp_flag);
        check_field("sao_flag", o_params.sao_flag, exp_params.sao_flag);
        check_field("num_st_rps", o_params.num_st_rps, exp_params.num_st_rps);
        repeat (4) @(posedge clk);                   // let done sit for the checker
    endtask

    // --------------------------------------------------
    // watchdog
    // --------------------------------------------------
    always @(posedge clk)
    begin
        run_cycles++;
        total_cycles++;
        if (run_cycles >= RUN_LIMIT || total_cycles >= TOTAL_LIMIT)
        begin
            $display("timeout: o_done never came within %0d cycles", RUN_LIMIT);
            $display("error count: %0d", errors + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(32'hdb1b_9cfa));
        rst          = 1'b1;
        i_en         = 1'b0;
        i_byte       = 8'h00;
        i_byte_valid = 1'b0;
        slow         = 1'b0;
        errors       = 0;
        run_cycles   = 0;
        total_cycles = 0;
        for (int run = 0; run < NUM_RUNS; run++)
            run_stream(run);
        errors = errors + uut.u_checker.fail_count;  // bound assertion failures
        $display("error count: %0d", errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* sps_parser_checker.sv */
`timescale 1ns/1ns

module sps_parser_checker import sps_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        i_done,
    input sps_params_t i_params
);

    int fail_count = 0;                      // read by the testbench at the end

    // --------------------------------------------------
    // done and parameter stability
    // --------------------------------------------------
    done_low_after_reset: assert property (@(posedge clk) rst |=> !i_done)
        else
        begin
            fail_count++;
            $error("o_done is high in the cycle after reset");
        end

    done_held: assert property (@(posedge clk) disable iff (rst) i_done |=> i_done)
        else
        begin
            fail_count++;
            $error("o_done fell without a reset");
        end

    params_held: assert property (@(posedge clk) disable iff (rst)
                                  i_done |=> $stable(i_params))
        else
        begin
            fail_count++;
            $error("o_params moved after o_done");
        end

    params_frozen: assert property (@(posedge clk) disable iff (rst)
                                    i_done |-> $stable(i_params))
        else
        begin
            fail_count++;
            $error("o_params changed while o_done was high");
        end

endmodule

bind sps_parser_top sps_parser_checker u_checker
(
    .clk      (clk),
    .rst      (rst),
    .i_done   (o_done),
    .i_params (o_params)
);

/* sps_parser_top.sv */
`timescale 1ns/1ns

module sps_parser_top import sps_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        i_en,
    input  logic [7:0]  i_byte,
    input  logic        i_byte_valid,
    output logic        o_need_byte,
    output sps_params_t o_params,
    output logic        o_done
);

    window_t   window;
    read_req_t read_req;
    field_wr_t field_wr;

    bit_window u_window
    (
        .clk          (clk),
        .rst          (rst),
        .i_byte       (i_byte),
        .i_byte_valid (i_byte_valid),
        .i_read       (read_req),
        .o_window     (window),
        .o_need_byte  (o_need_byte)
    );

    sps_field_sequencer u_seq
    (
        .clk        (clk),
        .rst        (rst),
        .i_en       (i_en),
        .i_window   (window),
        .o_read     (read_req),
        .o_field_wr (field_wr)
    );

    sps_param_regs u_regs
    (
        .clk        (clk),
        .rst        (rst),
        .i_field_wr (field_wr),
        .o_params   (o_params),
        .o_done     (o_done)
    );

endmodule

/* sps_param_regs.sv */
`timescale 1ns/1ns

module sps_param_regs import sps_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  field_wr_t   i_field_wr,
    output sps_params_t o_params,
    output logic        o_done
);

    logic [UE_W-1:0] v;

    assign v = i_field_wr.value;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            o_params <= '0;
            o_done   <= 1'b0;
        end
        else if (i_field_wr.wr)
        begin
            case (i_field_wr.id)
                FLD_CHROMA_FORMAT:   o_params.chroma_format_idc <= v[1:0];
                FLD_PIC_WIDTH:       o_params.pic_width <= v[12:0];
                FLD_PIC_HEIGHT:      o_params.pic_height <= v[11:0];
                FLD_LOG2_POC_LSB:    o_params.log2_max_poc_lsb_minus4 <= v[3:0];
                FLD_MAX_DEC_PIC_BUF: o_params.max_dec_pic_buffering_minus1 <= v[4:0];
                FLD_LOG2_MIN_CB:     o_params.log2_min_cb_minus3 <= v[1:0];
                FLD_LOG2_DIFF_CB:    o_params.log2_diff_cb <= v[1:0];
                FLD_LOG2_MIN_TB:     o_params.log2_min_tb_minus2 <= v[1:0];
                FLD_LOG2_DIFF_TB:    o_params.log2_diff_tb <= v[1:0];
                FLD_DEPTH_INTER:     o_params.depth_inter <= v[2:0];
                FLD_DEPTH_INTRA:     o_params.depth_intra <= v[2:0];
                FLD_FLAG_GROUP:
                begin
                    o_params.amp_flag <= v[2];   // second bit of group
                    o_params.sao_flag <= v[1];
                end
                FLD_NUM_ST_RPS:      o_params.num_st_rps <= v[3:0];
                FLD_END:             o_done <= 1'b1;
                default: ;
            endcase
        end
    end

endmodule

/* sps_field_sequencer.sv */
`timescale 1ns/1ns

module sps_field_sequencer import sps_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_en,
    input  window_t   i_window,
    output read_req_t o_read,
    output field_wr_t o_field_wr
);

    seq_state_e      state_q;
    field_id_e       field_q;                // next ue element
    logic [3:0]      skip_cnt_q;
    field_wr_t       wr_q;
    logic            go;
    logic            ue_active;
    logic            head_bit;
    read_req_t       dec_read;
    read_req_t       own_read;
    logic [UE_W-1:0] dec_value;
    logic            dec_valid;

    assign go        = i_en && i_window.ready;
    assign ue_active = (state_q == SEQ_UE);
    assign head_bit  = i_window.view[VIEW_BITS-1];

    exp_golomb_decoder u_ue
    (
        .clk           (clk),
        .rst           (rst),
        .i_start       (ue_active),
        .i_window      (i_window),
        .i_en          (i_en),
        .o_read        (dec_read),
        .o_value       (dec_value),
        .o_value_valid (dec_valid)
    );

    always_comb
    begin
        own_read = '0;
        case (state_q)
            SEQ_SKIP:                    own_read.count = 5'd8;
            SEQ_CONF_FLAG, SEQ_SUB_FLAG: own_read.count = 5'd1;
            SEQ_FLAG_GROUP:              own_read.count = 5'd4;
            default:                     own_read.count = 5'd0;
        endcase
        own_read.strobe = go && (own_read.count != 5'd0);
    end

    assign o_read     = ue_active ? dec_read : own_read;
    assign o_field_wr = wr_q;

    // --------------------------------------------------
    // syntax walk
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q    <= SEQ_SKIP;
            field_q    <= FLD_SPS_ID;
            skip_cnt_q <= '0;
            wr_q       <= '0;
        end
        else
        begin
            wr_q.wr <= 1'b0;
            case (state_q)
                SEQ_SKIP:
                    if (go)
                    begin
                        skip_cnt_q <= skip_cnt_q + 4'd1;
                        if (skip_cnt_q == 4'(HEADER_SKIP_BITS / 8 - 1))
                            state_q <= SEQ_UE;
                    end
                SEQ_UE:
                    if (dec_valid)
                    begin
                        wr_q <= '{wr: 1'b1, id: field_q, value: dec_value};
                        case (field_q)
                            FLD_PIC_HEIGHT:   state_q <= SEQ_CONF_FLAG;
                            FLD_LOG2_POC_LSB: state_q <= SEQ_SUB_FLAG;
                            FLD_DEPTH_INTRA:  state_q <= SEQ_FLAG_GROUP;
                            FLD_NUM_ST_RPS:   state_q <= SEQ_END;
                            default:          field_q <= field_id_e'(field_q + 5'd1);
                        endcase
                    end
                SEQ_CONF_FLAG:
                    if (go)
                    begin
                        wr_q    <= '{wr: 1'b1, id: FLD_CONF_FLAG, value: UE_W'(head_bit)};
                        field_q <= head_bit ? FLD_CONF_LEFT : FLD_BIT_DEPTH_LUMA;
                        state_q <= SEQ_UE;
                    end
                SEQ_SUB_FLAG:
                    if (go)
                    begin
                        wr_q    <= '{wr: 1'b1, id: FLD_SUB_LAYER_FLAG, value: UE_W'(head_bit)};
                        field_q <= FLD_MAX_DEC_PIC_BUF;   // one sub-layer only
                        state_q <= SEQ_UE;
                    end
                SEQ_FLAG_GROUP:
                    if (go)
                    begin
                        wr_q <= '{wr: 1'b1, id: FLD_FLAG_GROUP,
                                  value: UE_W'(i_window.view[VIEW_BITS-1 -: 4])};
                        field_q <= FLD_NUM_ST_RPS;
                        state_q <= SEQ_UE;
                    end
                SEQ_END:
                    if (i_en)
                    begin
                        wr_q    <= '{wr: 1'b1, id: FLD_END, value: '0};
                        state_q <= SEQ_IDLE;
                    end
                default: ;                   // idle until reset
            endcase
        end
    end

endmodule

/* exp_golomb_decoder.sv */
`timescale 1ns/1ns

module exp_golomb_decoder import sps_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            i_start,
    input  window_t         i_window,
    input  logic            i_en,
    output read_req_t       o_read,
    output logic [UE_W-1:0] o_value,
    output logic            o_value_valid
);

    logic            in_suffix;
    logic [4:0]      zeros;
    logic [4:0]      zeros_q;
    logic [4:0]      left_q;                 // suffix bits still to read
    logic [4:0]      chunk_len;
    logic [UE_W-1:0] chunk;
    logic [UE_W-1:0] acc_q;
    logic [UE_W-1:0] acc_next;
    logic            step;
    logic            last_chunk;

    assign zeros = (i_window.zeros > 5'(MAX_UE_ZEROS)) ? 5'(MAX_UE_ZEROS) : i_window.zeros;
    assign step  = i_en && i_window.ready && (in_suffix || i_start);

    assign last_chunk = (left_q <= 5'(SUFFIX_CHUNK));
    assign chunk_len  = last_chunk ? left_q : 5'(SUFFIX_CHUNK);
    assign chunk      = UE_W'(i_window.view >> (5'(VIEW_BITS) - chunk_len));
    assign acc_next   = (acc_q << chunk_len) | chunk;

    assign o_read.strobe = step;
    assign o_read.count  = in_suffix ? chunk_len : zeros + 5'd1;   // prefix plus stop bit

    assign o_value_valid = step && (in_suffix ? last_chunk : (zeros == 5'd0));
    assign o_value = in_suffix ? ((UE_W'(1) << zeros_q) - UE_W'(1)) + acc_next : '0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            in_suffix <= 1'b0;
            left_q    <= '0;
        end
        else if (step)
        begin
            if (!in_suffix)
            begin
                left_q    <= zeros;
                in_suffix <= (zeros != 5'd0);
            end
            else
            begin
                left_q <= left_q - chunk_len;
                if (last_chunk)
                    in_suffix <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (step)
        begin
            if (!in_suffix)
            begin
                acc_q   <= '0;
                zeros_q <= zeros;
            end
            else
                acc_q <= acc_next;
        end
    end

endmodule

/* bit_window.sv */
`timescale 1ns/1ns

module bit_window import sps_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] i_byte,
    input  logic       i_byte_valid,
    input  read_req_t  i_read,
    output window_t    o_window,
    output logic       o_need_byte
);

    logic [BUF_BITS-1:0]  buf_q;             // left aligned, zero below fill
    logic [FILL_W-1:0]    fill_q;
    logic [BUF_BITS-1:0]  shifted;
    logic [FILL_W-1:0]    fill_left;
    logic [FILL_W-1:0]    consume;
    logic [VIEW_BITS-1:0] view;

    function automatic logic [4:0] lead_zeros(input logic [VIEW_BITS-1:0] v);
        logic [4:0] n;
        n = 5'(VIEW_BITS);
        for (int i = 0; i < VIEW_BITS; i++)
        begin
            if (v[i])
                n = 5'(VIEW_BITS - 1 - i);   // highest set bit wins
        end
        return n;
    endfunction

    assign consume   = i_read.strobe ? FILL_W'(i_read.count) : '0;
    assign shifted   = buf_q << consume;
    assign fill_left = fill_q - consume;
    assign view      = buf_q[BUF_BITS-1 -: VIEW_BITS];

    assign o_window.view  = view;
    assign o_window.zeros = lead_zeros(view);
    assign o_window.ready = (fill_q >= FILL_W'(MIN_VIEW_FILL));
    assign o_need_byte    = (fill_q <= FILL_W'(NEED_LEVEL));

    // --------------------------------------------------
    // consume first, then append at the new fill point
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            buf_q  <= '0;
            fill_q <= '0;
        end
        else if (i_byte_valid)
        begin
            buf_q  <= shifted | ({i_byte, {(BUF_BITS-8){1'b0}}} >> fill_left);
            fill_q <= fill_left + FILL_W'(8);
        end
        else
        begin
            buf_q  <= shifted;
            fill_q <= fill_left;
        end
    end

endmodule

/* sps_pkg.sv */
package sps_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------
    localparam int BUF_BITS         = 32;
    localparam int VIEW_BITS        = 16;
    localparam int FILL_W           = 6;
    localparam int HEADER_SKIP_BITS = 104;
    localparam int MAX_UE_ZEROS     = 15;
    localparam int SUFFIX_CHUNK     = 8;
    localparam int UE_W             = 16;
    localparam int NEED_LEVEL       = 24;    // request while fill <= this
    localparam int MIN_VIEW_FILL    = 16;

    typedef struct packed {
        logic [VIEW_BITS-1:0] view;          // msb is next bit in stream
        logic [4:0]           zeros;
        logic                 ready;
    } window_t;

    typedef struct packed {
        logic       strobe;
        logic [4:0] count;
    } read_req_t;

    // syntax order, discarded elements included
    typedef enum logic [4:0] {
        FLD_SPS_ID, FLD_CHROMA_FORMAT, FLD_PIC_WIDTH, FLD_PIC_HEIGHT,
        FLD_CONF_FLAG, FLD_CONF_LEFT, FLD_CONF_RIGHT, FLD_CONF_TOP, FLD_CONF_BOTTOM,
        FLD_BIT_DEPTH_LUMA, FLD_BIT_DEPTH_CHROMA, FLD_LOG2_POC_LSB, FLD_SUB_LAYER_FLAG,
        FLD_MAX_DEC_PIC_BUF, FLD_NUM_REORDER, FLD_MAX_LATENCY,
        FLD_LOG2_MIN_CB, FLD_LOG2_DIFF_CB, FLD_LOG2_MIN_TB, FLD_LOG2_DIFF_TB,
        FLD_DEPTH_INTER, FLD_DEPTH_INTRA, FLD_FLAG_GROUP, FLD_NUM_ST_RPS, FLD_END
    } field_id_e;

    typedef struct packed {
        logic [1:0]  chroma_format_idc;
        logic [12:0] pic_width;
        logic [11:0] pic_height;
        logic [3:0]  log2_max_poc_lsb_minus4;
        logic [4:0]  max_dec_pic_buffering_minus1;
        logic [1:0]  log2_min_cb_minus3;
        logic [1:0]  log2_diff_cb;
        logic [1:0]  log2_min_tb_minus2;
        logic [1:0]  log2_diff_tb;
        logic [2:0]  depth_inter;
        logic [2:0]  depth_intra;
        logic        amp_flag;
        logic        sao_flag;
        logic [3:0]  num_st_rps;
    } sps_params_t;

    typedef struct packed {
        logic            wr;
        field_id_e       id;
        logic [UE_W-1:0] value;
    } field_wr_t;

    typedef enum logic [2:0] {
        SEQ_SKIP, SEQ_UE, SEQ_CONF_FLAG, SEQ_SUB_FLAG, SEQ_FLAG_GROUP, SEQ_END, SEQ_IDLE
    } seq_state_e;

endpackage
